/* bench/ipv4_hdr_path_assertions.sv */
// Protocol checks bound into the header path. All checks are off while arst_n is low.
`timescale 1ns/1ps

module ipv4_hdr_path_assertions (
    input logic clk,
    input logic arst_n,
    input logic rd_en,
    input logic empty,
    input logic in_full,
    input logic overflow,
    input logic result_valid
);

    // A lone pop gives exactly one result pulse two cycles later
    property lone_pop_single_result;
        @(posedge clk) disable iff (!arst_n)
        (rd_en && !$past(rd_en)) ##1 !rd_en |=> result_valid ##1 !result_valid;
    endproperty

    lone_pop_a : assert property (lone_pop_single_result)
        else $error("result_valid is not a single pulse after a lone pop");

    // Headers are only dropped when the FIFO is full
    // and the FIFO stays full afterwards unless a pop went out
    overflow_full_a : assert property (@(posedge clk) disable iff (!arst_n)
        overflow |-> in_full ##1 (in_full || $past(rd_en)))
        else $error("overflow while not full, or the dropped write changed the fill");

    // At most one pop per cycle, so a full FIFO is not empty now or one cycle later
    full_empty_a : assert property (@(posedge clk) disable iff (!arst_n)
        in_full |-> !empty ##1 !empty)
        else $error("FIFO reports empty while or just after reporting full");

endmodule

bind ipv4_hdr_path ipv4_hdr_path_assertions assertions_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .rd_en        (rd_en),
    .empty        (empty),
    .in_full      (in_full),
    .overflow     (overflow),
    .result_valid (result_valid)
);

/* bench/ipv4_hdr_path_tb.sv */
// Testbench for the IPv4 header path. Reads bench/ipv4_hdr_path_vectors.txt relative
// to the project root, then sends LCG random headers; must run from the project root.
`timescale 1ns/1ps
`include "ipv4_hdr_defines.svh"

module ipv4_hdr_path_tb
    import ipv4_hdr_pkg::*;
();

    localparam int N_RANDOM      = 24;
    localparam int DRAIN_TIMEOUT = 400;

    logic         clk;
    logic         arst_n;
    logic         hdr_strobe;
    logic         chksum_gen;
    logic [5:0]   dscp;
    logic [1:0]   ecn;
    ipv4_word_t   total_length;
    ipv4_word_t   identification;
    logic [2:0]   flags;
    logic [12:0]  fragment_offset;
    logic [7:0]   ttl;
    logic [7:0]   protocol;
    ipv4_word_t   hdr_chksum;
    logic [31:0]  source_ip;
    logic [31:0]  dest_ip;
    logic         stall;
    logic         in_full;
    logic         overflow;
    logic         result_valid;
    logic         chksum_ok;
    ipv4_header_t header;

    // Predictions wait in pend_* until their write is seen, then in exp_*
    ipv4_header_t pend_hdr [$];
    logic         pend_ok [$];
    ipv4_header_t exp_hdr [$];
    logic         exp_ok [$];
    ipv4_header_t head_hdr;
    logic         head_ok;
    logic         wr_pending;
    logic         saw_full;
    int           fifo_count;
    logic         model_full;
    logic         model_pop;
    logic [31:0]  lcg_state;
    int           errors;
    int           results;
    int           dropped;

    ipv4_hdr_path dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////
    // Reference model

    // Ones-complement sum of all ten words folded until no carry is left
    function automatic ipv4_word_t ones_sum(input ipv4_header_t h);
        logic [31:0] acc;
        acc = '0;
        for (int i = 0; i < 10; i++) begin
            acc = acc + h[16*i +: 16];
        end
        while (acc[31:16] != 0) begin
            acc = acc[15:0] + acc[31:16];
        end
        return acc[15:0];
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic report_mismatch(input string name, input logic [159:0] got,
                                   input logic [159:0] exp);
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    //////////////////////////////////////////////////////////////
    // Stimulus

    // h carries the fields with a zero checksum word
    task automatic send_header(input ipv4_header_t h, input logic gen, input ipv4_word_t mask,
                               input logic stall_v, input logic ok_v, input logic use_ok);
        ipv4_word_t   good;
        ipv4_header_t pred;
        logic         pred_ok;
        good        = ~ones_sum(h);
        pred        = h;
        pred[79:64] = gen ? good : (good ^ mask);
        pred_ok     = (ones_sum(pred) == 16'hffff);
        if (use_ok && (ok_v != pred_ok)) begin
            $display("ERROR: vector ok flag %0d disagrees with the checksum rule", ok_v);
            errors++;
        end
        @(posedge clk);
        hdr_strobe      <= 1'b1;
        chksum_gen      <= gen;
        dscp            <= h[151:146];
        ecn             <= h[145:144];
        total_length    <= h[143:128];
        identification  <= h[127:112];
        flags           <= h[111:109];
        fragment_offset <= h[108:96];
        ttl             <= h[95:88];
        protocol        <= h[87:80];
        hdr_chksum      <= good ^ mask;
        source_ip       <= h[63:32];
        dest_ip         <= h[31:0];
        stall           <= stall_v;
        pend_hdr.push_back(pred);
        pend_ok.push_back(use_ok ? ok_v : pred_ok);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            hdr_strobe <= 1'b0;
        end
    endtask

    task automatic run_file();
        int           fd;
        int           n;
        string        line;
        logic [31:0]  col [14];
        ipv4_header_t h;
        fd = $fopen("bench/ipv4_hdr_path_vectors.txt", "r");
        if (fd == 0) begin
            $display("ERROR: vector file could not be opened");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 4 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                        col[7], col[8], col[9], col[10], col[11], col[12], col[13]);
            if (n != 14) begin
                $display("ERROR: vector line has %0d fields instead of 14", n);
                errors++;
                continue;
            end
            h = {`IPV4_VERSION, `IPV4_IHL, col[0][5:0], col[1][1:0], col[2][15:0],
                 col[3][15:0], col[4][2:0], col[5][12:0], col[6][7:0], col[7][7:0],
                 16'h0000, col[8], col[9]};
            send_header(h, col[10][0], col[11][15:0], col[12][0], col[13][0], 1'b1);
        end
        $fclose(fd);
    endtask

    task automatic run_random();
        ipv4_header_t h;
        logic [31:0]  r;
        for (int k = 0; k < N_RANDOM; k++) begin
            for (int w = 0; w < 5; w++) begin
                h[32*w +: 32] = lcg_next();
            end
            h[159:152] = {`IPV4_VERSION, `IPV4_IHL};
            h[79:64]   = 16'h0000;
            r = lcg_next();
            send_header(h, r[0], r[1] ? 16'h0000 : (r[31:16] | 16'h0001), 1'b0, 1'b0, 1'b0);
            idle_cycles(r[3:2]);
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((pend_hdr.size() != 0 || exp_hdr.size() != 0) && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= DRAIN_TIMEOUT) begin
            $display("ERROR: timeout, %0d headers never came out",
                     pend_hdr.size() + exp_hdr.size());
            errors++;
        end
    endtask

    task automatic check_idle_outputs();
        if (result_valid !== 1'b0) report_mismatch("result_valid", result_valid, 0);
        if (overflow !== 1'b0) report_mismatch("overflow", overflow, 0);
        if (in_full !== 1'b0) report_mismatch("in_full", in_full, 0);
    endtask

    //////////////////////////////////////////////////////////////
    // Monitor and scoreboard

    always @(posedge clk) begin
        if (arst_n) begin
            if (in_full) begin
                saw_full = 1'b1;
            end
            // FIFO fill level follows at most one write and one pop per cycle
            model_full = (fifo_count == `IPV4_HDR_FIFO_DEPTH);
            model_pop  = (fifo_count != 0) && !stall;
            if (in_full !== model_full) begin
                report_mismatch("in_full", in_full, model_full);
            end
            if (overflow !== (wr_pending && model_full)) begin
                report_mismatch("overflow", overflow, wr_pending && model_full);
            end
            // The write lands one cycle after the strobe
            if (wr_pending && pend_hdr.size() != 0) begin
                head_hdr = pend_hdr.pop_front();
                head_ok  = pend_ok.pop_front();
                if (model_full) begin
                    dropped++;
                end else begin
                    exp_hdr.push_back(head_hdr);
                    exp_ok.push_back(head_ok);
                    fifo_count++;
                end
            end
            if (model_pop) begin
                fifo_count--;
            end
            wr_pending = hdr_strobe;
            if (result_valid) begin
                if (exp_hdr.size() == 0) begin
                    $display("ERROR at %0t: result with no header expected", $time);
                    errors++;
                end else begin
                    head_hdr = exp_hdr.pop_front();
                    head_ok  = exp_ok.pop_front();
                    results++;
                    if (header !== head_hdr) report_mismatch("header", header, head_hdr);
                    if (chksum_ok !== head_ok) report_mismatch("chksum_ok", chksum_ok, head_ok);
                end
            end
        end
    end

    initial begin
        {hdr_strobe, chksum_gen, dscp, ecn, total_length, identification} = '0;
        {flags, fragment_offset, ttl, protocol, hdr_chksum, source_ip, dest_ip} = '0;
        stall      = 1'b0;
        arst_n     = 1'b0;
        wr_pending = 1'b0;
        saw_full   = 1'b0;
        fifo_count = 0;
        lcg_state  = 32'd96573;
        errors     = 0;
        results    = 0;
        dropped    = 0;
        repeat (16) begin
            @(posedge clk);
            check_idle_outputs();
        end
        arst_n <= 1'b1;
        @(posedge clk);
        check_idle_outputs();

        run_file();
        idle_cycles(3);
        run_random();
        idle_cycles(2);
        wait_drain();
        if (dropped == 0 || !saw_full) begin
            $display("ERROR: stalled burst did not fill the FIFO and drop headers");
            errors++;
        end

        $display("errors: %0d  results: %0d  dropped: %0d", errors, results, dropped);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* bench/ipv4_hdr_path_vectors.txt */
# dscp ecn total_length identification flags frag_off ttl protocol source_ip dest_ip (hex)
# then chksum_gen, checksum xor mask (0 = correct value), stall level, expected chksum_ok
00 0 0054 1c46 2 0000 40 06 c0a80001 c0a800c7 1 0000 0 1
2e 1 0028 abcd 0 0000 80 11 0a000001 0a0000fe 1 1234 0 1
00 0 003c 0001 2 0000 40 06 ac100a63 ac100a0c 0 0000 0 1
12 2 05dc beef 1 00b9 20 11 08080808 01020304 0 0001 0 0
3f 3 ffff ffff 7 1fff ff ff ffffffff ffffffff 1 0000 0 1
00 0 0014 0000 0 0000 01 01 00000000 00000000 0 8000 0 0
0a 0 0100 4242 2 0000 40 06 7f000001 7f000001 0 0000 0 1
01 1 0030 1001 0 0000 40 06 c0000201 c6336401 1 0000 1 1
02 2 0031 1002 0 0000 40 11 c0000202 c6336402 0 0000 1 1
03 3 0032 1003 0 0000 40 06 c0000203 c6336403 0 00ff 1 0
04 0 0033 1004 2 0000 40 01 c0000204 c6336404 1 0000 1 1
05 1 0034 1005 2 0000 40 06 c0000205 c6336405 1 0000 1 1
06 2 0035 1006 2 0000 40 11 c0000206 c6336406 0 0000 1 1
07 3 0036 1007 0 0000 40 06 c0000207 c6336407 1 0000 0 1
08 0 0037 1008 0 0000 40 06 c0000208 c6336408 0 4000 0 0
09 1 0038 1009 0 0000 40 06 c0000209 c6336409 0 0000 0 1

/* ipv4_hdr_path.f */
+incdir+verilog
verilog/ipv4_hdr_pkg.sv
verilog/ipv4_checksum_insert.sv
verilog/ipv4_header_fifo.sv
verilog/ipv4_checksum_verify.sv
verilog/ipv4_hdr_path.sv
bench/ipv4_hdr_path_assertions.sv
bench/ipv4_hdr_path_tb.sv

/* verilog/ipv4_checksum_insert.sv */
// Header producer. Fields are sampled on hdr_strobe; the FIFO full flag is not seen
// here, so a strobe while the FIFO is full is lost downstream.
`timescale 1ns/1ps
`include "ipv4_hdr_defines.svh"

module ipv4_checksum_insert
    import ipv4_hdr_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         hdr_strobe,
    input  logic         chksum_gen,
    input  logic [5:0]   dscp,
    input  logic [1:0]   ecn,
    input  ipv4_word_t   total_length,
    input  ipv4_word_t   identification,
    input  logic [2:0]   flags,
    input  logic [12:0]  fragment_offset,
    input  logic [7:0]   ttl,
    input  logic [7:0]   protocol,
    input  ipv4_word_t   hdr_chksum,
    input  logic [31:0]  source_ip,
    input  logic [31:0]  dest_ip,
    output logic         wr_en,
    output ipv4_header_t wr_header
);

    //////////////////////////////////////////////////////////////
    // Field packing

    ipv4_header_t hdr_base;
    ipv4_header_t hdr_next;
    ipv4_word_t   words [IPV4_HDR_WORDS];
    logic [19:0]  sum_raw;
    logic [16:0]  sum_fold1;
    ipv4_word_t   sum_fold2;
    ipv4_word_t   chksum_calc;
    ipv4_word_t   chksum_sel;

    // Checksum field left at zero so it drops out of the sum
    assign hdr_base = {`IPV4_VERSION, `IPV4_IHL, dscp, ecn,
                       total_length,
                       identification,
                       flags, fragment_offset,
                       ttl, protocol,
                       16'h0000,
                       source_ip,
                       dest_ip};

    //////////////////////////////////////////////////////////////
    // Ones-complement sum of the nine remaining words

    always_comb begin
        for (int i = 0; i < IPV4_HDR_WORDS; i++) begin
            words[i] = hdr_base[16*i +: 16];
        end
    end

    always_comb begin
        sum_raw = '0;
        for (int i = 0; i < IPV4_HDR_WORDS; i++) begin
            sum_raw = sum_raw + 20'(words[i]);
        end
    end

    // Two end-around folds are enough for ten words
    assign sum_fold1   = 17'(sum_raw[15:0]) + 17'(sum_raw[19:16]);
    assign sum_fold2   = sum_fold1[15:0] + 16'(sum_fold1[16]);
    assign chksum_calc = ~sum_fold2;

    assign chksum_sel = chksum_gen ? chksum_calc : hdr_chksum;

    always_comb begin
        hdr_next = hdr_base;
        hdr_next[IPV4_CHKSUM_LSB +: 16] = chksum_sel;
    end

    //////////////////////////////////////////////////////////////
    // Output register

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= hdr_strobe;
        end
    end

    // Header only loads on a strobe, held otherwise
    always_ff @(posedge clk) begin
        if (hdr_strobe) begin
            wr_header <= hdr_next;
        end
    end

endmodule

/* verilog/ipv4_checksum_verify.sv */
// Checksum verifier. Pops whenever the FIFO has data and stall is low; each pop
// gives one result two cycles later, in order.
`timescale 1ns/1ps

module ipv4_checksum_verify
    import ipv4_hdr_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         empty,
    input  logic         stall,
    input  ipv4_header_t rd_header,
    output logic         rd_en,
    output logic         result_valid,
    output logic         chksum_ok,
    output ipv4_header_t header
);

    //////////////////////////////////////////////////////////////
    // Pop control

    // Stall only holds back new pops, the pipeline keeps draining
    assign rd_en = !empty && !stall;

    //////////////////////////////////////////////////////////////
    // Stage 1, raw sum of all ten words

    ipv4_word_t   words [IPV4_HDR_WORDS];
    logic [19:0]  sum_next;

    logic         s1_valid;
    logic [19:0]  s1_sum;
    ipv4_header_t s1_header;

    always_comb begin
        for (int i = 0; i < IPV4_HDR_WORDS; i++) begin
            words[i] = rd_header[16*i +: 16];
        end
    end

    always_comb begin
        sum_next = '0;
        for (int i = 0; i < IPV4_HDR_WORDS; i++) begin
            sum_next = sum_next + 20'(words[i]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            s1_sum    <= sum_next;
            s1_header <= rd_header;
        end
    end

    //////////////////////////////////////////////////////////////
    // Stage 2, fold and compare

    logic [16:0] sum_fold1;
    ipv4_word_t  sum_fold2;
    logic        sum_match;

    assign sum_fold1 = 17'(s1_sum[15:0]) + 17'(s1_sum[19:16]);
    assign sum_fold2 = sum_fold1[15:0] + 16'(sum_fold1[16]);

    // A good header, checksum included, sums to all ones
    assign sum_match = &sum_fold2;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            chksum_ok    <= 1'b0;
        end else begin
            result_valid <= s1_valid;
            if (s1_valid) begin
                chksum_ok <= sum_match;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            header <= s1_header;
        end
    end

endmodule

/* verilog/ipv4_hdr_defines.svh */
// Build-time constants for the IPv4 header path. Only option-free headers are
// handled, so version and IHL are fixed. FIFO depth must be a power of two, 2 or more.

`ifndef IPV4_HDR_DEFINES_SVH
`define IPV4_HDR_DEFINES_SVH

// Default number of headers held between producer and verifier
`define IPV4_HDR_FIFO_DEPTH 4

// Version nibble for IPv4
`define IPV4_VERSION 4'd4

// Header length in 32-bit words, no options
`define IPV4_IHL 4'd5

`endif

/* verilog/ipv4_hdr_path.sv */
// IPv4 header path, producer to FIFO to verifier. Latency is 4 cycles from strobe
// to result when the FIFO is empty and stall is low; strobes while full are dropped.
`timescale 1ns/1ps
`include "ipv4_hdr_defines.svh"

module ipv4_hdr_path
    import ipv4_hdr_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         hdr_strobe,
    input  logic         chksum_gen,
    input  logic [5:0]   dscp,
    input  logic [1:0]   ecn,
    input  ipv4_word_t   total_length,
    input  ipv4_word_t   identification,
    input  logic [2:0]   flags,
    input  logic [12:0]  fragment_offset,
    input  logic [7:0]   ttl,
    input  logic [7:0]   protocol,
    input  ipv4_word_t   hdr_chksum,
    input  logic [31:0]  source_ip,
    input  logic [31:0]  dest_ip,
    input  logic         stall,
    output logic         in_full,
    output logic         overflow,
    output logic         result_valid,
    output logic         chksum_ok,
    output ipv4_header_t header
);

    logic         wr_en;
    ipv4_header_t wr_header;
    logic         rd_en;
    ipv4_header_t rd_header;
    logic         empty;

    //////////////////////////////////////////////////////////////
    // Producer

    ipv4_checksum_insert insert_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .hdr_strobe      (hdr_strobe),
        .chksum_gen      (chksum_gen),
        .dscp            (dscp),
        .ecn             (ecn),
        .total_length    (total_length),
        .identification  (identification),
        .flags           (flags),
        .fragment_offset (fragment_offset),
        .ttl             (ttl),
        .protocol        (protocol),
        .hdr_chksum      (hdr_chksum),
        .source_ip       (source_ip),
        .dest_ip         (dest_ip),
        .wr_en           (wr_en),
        .wr_header       (wr_header)
    );

    //////////////////////////////////////////////////////////////
    // Header buffer

    ipv4_header_fifo #(
        .DEPTH (`IPV4_HDR_FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_en     (wr_en),
        .wr_header (wr_header),
        .rd_en     (rd_en),
        .rd_header (rd_header),
        .empty     (empty),
        .full      (in_full),
        .overflow  (overflow)
    );

    //////////////////////////////////////////////////////////////
    // Verifier

    ipv4_checksum_verify verify_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .empty        (empty),
        .stall        (stall),
        .rd_header    (rd_header),
        .rd_en        (rd_en),
        .result_valid (result_valid),
        .chksum_ok    (chksum_ok),
        .header       (header)
    );

endmodule

/* verilog/ipv4_hdr_pkg.sv */
// Types shared by the IPv4 header path. The header is a 20-byte vector with no
// options, in network order with version in the top bits.

package ipv4_hdr_pkg;

    //////////////////////////////////////////////////////////////
    // Header layout

    // Full header, bit 159 is the first bit on the wire
    typedef logic [159:0] ipv4_header_t;

    // One 16-bit header word, the unit of the checksum
    typedef logic [15:0] ipv4_word_t;

    // Ten words make up an option-free header
    localparam int IPV4_HDR_WORDS = 10;

    // Checksum field position, bits 79..64 of the header
    localparam int IPV4_CHKSUM_LSB = 64;

endpackage

/* verilog/ipv4_header_fifo.sv */
// Header FIFO with a combinational read port. DEPTH must be a power of two, 2 or more.
// Writes while full are dropped; reads while empty are ignored.
`timescale 1ns/1ps

module ipv4_header_fifo
    import ipv4_hdr_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         wr_en,
    input  ipv4_header_t wr_header,
    input  logic         rd_en,
    output ipv4_header_t rd_header,
    output logic         empty,
    output logic         full,
    output logic         overflow
);

    localparam int AW = $clog2(DEPTH);

    //////////////////////////////////////////////////////////////
    // Storage and pointers

    ipv4_header_t mem [DEPTH];

    // Extra top bit tells a full buffer from an empty one
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    logic do_write;
    logic do_read;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // Flag the lost header in the same cycle as the write attempt
    assign overflow = wr_en && full;

    //////////////////////////////////////////////////////////////
    // Write side

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= wr_header;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
        end else if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////
    // Read side

    // Oldest entry is always on the output, the pop just moves the pointer
    assign rd_header = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
        end else if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule
